/* logic/cxl_mem_pkg.sv */
`default_nettype none

package cxl_mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and capacity
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W     = 64;
    localparam int ID_W       = 16;
    localparam int LINE_BYTES = 64;
    localparam int OFFSET_W   = 6;
    localparam int DATA_W     = LINE_BYTES * 8;
    localparam int LINE_COUNT = 256;
    localparam int INDEX_W    = 8;
    localparam int VER_W      = 8;

    // Host physical window served by this endpoint
    localparam logic [ADDR_W-1:0] HDM_BASE = 64'h0000_0010_0000_0000;
    localparam logic [ADDR_W-1:0] HDM_SIZE = ADDR_W'(LINE_COUNT * LINE_BYTES);

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } cxl_resp_e;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_W_DATA = 3'd1,
        ST_W_RESP = 3'd2,
        ST_R_READ = 3'd3,
        ST_R_DATA = 3'd4
    } ctrl_state_e;

    // Metadata returned with every read
    typedef struct packed {
        logic             written;
        logic [ID_W-1:0]  owner_id;
        logic [VER_W-1:0] version;
    } line_tag_t;

    // R channel payload
    typedef struct packed {
        logic [ID_W-1:0]   id;
        cxl_resp_e         resp;
        line_tag_t         tag;
        logic [DATA_W-1:0] data;
    } rd_beat_t;

    // B channel payload
    typedef struct packed {
        logic [ID_W-1:0] id;
        cxl_resp_e       resp;
    } wr_resp_t;

endpackage

`default_nettype wire

/* logic/cxl_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_addr_decode
    import cxl_mem_pkg::*;
(
    input  wire  [ADDR_W-1:0]  addr_i,
    output logic [INDEX_W-1:0] index_o,
    output logic               in_range_o
);

    // Byte offset into the window
    logic [ADDR_W-1:0] offset;
    logic              above_base;
    logic              below_top;
    logic              aligned;

    assign offset = addr_i - HDM_BASE;

    ////////////////////////////////////////////////////////////////////////////
    // Window and alignment checks
    ////////////////////////////////////////////////////////////////////////////

    // Offset wraps for addresses under the base, so check the base directly
    assign above_base = (addr_i >= HDM_BASE);
    assign below_top  = (offset < HDM_SIZE);

    // Only whole 64-byte lines are served
    assign aligned = (offset[OFFSET_W-1:0] == '0);

    assign in_range_o = above_base && below_top && aligned;

    // Line number inside the window
    assign index_o = offset[OFFSET_W +: INDEX_W];

endmodule

`default_nettype wire

/* logic/cxl_line_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_line_store
    import cxl_mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rd_i,
    input  wire                 wr_i,
    input  wire  [INDEX_W-1:0]  index_i,
    input  wire  [DATA_W-1:0]   wdata_i,
    output logic [DATA_W-1:0]   rdata_o
);

    // One full line per entry
    logic [DATA_W-1:0] mem [LINE_COUNT];

    // Full-line write
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[index_i] <= wdata_i;
        end
    end

    // Synchronous read, output holds until the next read strobe
    always_ff @(posedge clk) begin
        if (rd_i) begin
            rdata_o <= mem[index_i];
        end
    end

endmodule

`default_nettype wire

/* logic/cxl_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_tag_store
    import cxl_mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 rd_i,
    input  wire                 wr_i,
    input  wire  [INDEX_W-1:0]  index_i,
    input  wire  [ID_W-1:0]     owner_i,
    output line_tag_t           tag_o
);

    // Written flags in flops so reset can clear them
    logic [LINE_COUNT-1:0] written_q;

    // Owner and version live in plain arrays
    logic [ID_W-1:0]  owner_mem [LINE_COUNT];
    logic [VER_W-1:0] ver_mem   [LINE_COUNT];

    logic [VER_W-1:0] next_ver;
    logic             cur_written;

    assign cur_written = written_q[index_i];

    // First write of a line starts the count at 1, later ones wrap
    assign next_ver = cur_written ? ver_mem[index_i] + 1'b1 : VER_W'(1);

    ////////////////////////////////////////////////////////////////////////////
    // Flag update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            written_q <= '0;
        end else if (wr_i) begin
            written_q[index_i] <= 1'b1;
        end
    end

    // Owner and version write-back
    always_ff @(posedge clk) begin
        if (wr_i) begin
            owner_mem[index_i] <= owner_i;
            ver_mem[index_i]   <= next_ver;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag read
    ////////////////////////////////////////////////////////////////////////////

    // Never-written lines read as an all-zero tag
    always_ff @(posedge clk) begin
        if (rd_i) begin
            if (cur_written) begin
                tag_o.written  <= 1'b1;
                tag_o.owner_id <= owner_mem[index_i];
                tag_o.version  <= ver_mem[index_i];
            end else begin
                tag_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cxl_mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_mem_ctrl
    import cxl_mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,

    // AR channel
    input  wire  [ID_W-1:0]     arid_i,
    input  wire  [ADDR_W-1:0]   araddr_i,
    input  wire                 arvalid_i,
    output logic                arready_o,

    // R channel
    output logic                rvalid_o,
    input  wire                 rready_i,

    // AW channel
    input  wire  [ID_W-1:0]     awid_i,
    input  wire  [ADDR_W-1:0]   awaddr_i,
    input  wire                 awvalid_i,
    output logic                awready_o,

    // W channel
    input  wire                 wvalid_i,
    output logic                wready_o,

    // B channel
    output logic                bvalid_o,
    input  wire                 bready_i,

    // Address decoder
    output logic [ADDR_W-1:0]   req_addr_o,
    input  wire  [INDEX_W-1:0]  index_i,
    input  wire                 in_range_i,

    // Storage strobes
    output logic                line_rd_o,
    output logic                line_wr_o,
    output logic                tag_rd_o,
    output logic                tag_wr_o,
    output logic [INDEX_W-1:0]  index_o,

    // Response fields
    output logic [ID_W-1:0]     resp_id_o,
    output cxl_resp_e           resp_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic aw_rdy_q;
    logic ar_rdy_q;
    logic prefer_w_q;

    // Captured request
    logic [ID_W-1:0]   id_q;
    logic [ADDR_W-1:0] addr_q;
    cxl_resp_e         resp_q;
    cxl_resp_e         cur_resp;

    logic can_grant;
    logic grant_w;
    logic grant_r;
    logic aw_hs;
    logic ar_hs;
    logic w_hs;

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////////////

    // One ready pulse at a time, only from idle
    assign can_grant = (state_q == ST_IDLE) && !aw_rdy_q && !ar_rdy_q;

    // Alternate when both valids are up
    assign grant_w = can_grant && awvalid_i && (prefer_w_q || !arvalid_i);
    assign grant_r = can_grant && arvalid_i && (!prefer_w_q || !awvalid_i);

    assign awready_o = aw_rdy_q;
    assign arready_o = ar_rdy_q;

    assign aw_hs = aw_rdy_q && awvalid_i;
    assign ar_hs = ar_rdy_q && arvalid_i;
    assign w_hs  = wready_o && wvalid_i;

    // Handshake outputs follow the state
    assign wready_o = (state_q == ST_W_DATA);
    assign bvalid_o = (state_q == ST_W_RESP);
    assign rvalid_o = (state_q == ST_R_DATA);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (aw_hs) begin
                    state_d = ST_W_DATA;
                end else if (ar_hs) begin
                    state_d = ST_R_READ;
                end
            end
            ST_W_DATA: begin
                if (w_hs) begin
                    state_d = ST_W_RESP;
                end
            end
            ST_W_RESP: begin
                if (bready_i) begin
                    state_d = ST_IDLE;
                end
            end
            // Stores register the line during this cycle
            ST_R_READ: state_d = ST_R_DATA;
            ST_R_DATA: begin
                if (rready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            aw_rdy_q   <= 1'b0;
            ar_rdy_q   <= 1'b0;
            prefer_w_q <= 1'b1;
        end else begin
            state_q  <= state_d;
            aw_rdy_q <= grant_w;
            ar_rdy_q <= grant_r;
            if (aw_hs) begin
                prefer_w_q <= 1'b0;
            end else if (ar_hs) begin
                prefer_w_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request capture and datapath sequencing
    ////////////////////////////////////////////////////////////////////////////

    assign cur_resp = in_range_i ? RESP_OKAY : RESP_SLVERR;

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q   <= awid_i;
            addr_q <= awaddr_i;
        end else if (ar_hs) begin
            id_q   <= arid_i;
            addr_q <= araddr_i;
        end
        // Response code fixed when storage is touched
        if (state_q == ST_R_READ || w_hs) begin
            resp_q <= cur_resp;
        end
    end

    assign req_addr_o = addr_q;
    assign index_o    = index_i;

    // Bad requests never reach storage
    assign line_rd_o = (state_q == ST_R_READ) && in_range_i;
    assign tag_rd_o  = (state_q == ST_R_READ) && in_range_i;
    assign line_wr_o = w_hs && in_range_i;
    assign tag_wr_o  = w_hs && in_range_i;

    assign resp_id_o = id_q;
    assign resp_o    = resp_q;

endmodule

`default_nettype wire

/* logic/cxl_mem_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_mem_slave
    import cxl_mem_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,

    // AR channel
    input  wire  [ID_W-1:0]     arid_i,
    input  wire  [ADDR_W-1:0]   araddr_i,
    input  wire                 arvalid_i,
    output logic                arready_o,

    // R channel
    output rd_beat_t            r_beat_o,
    output logic                rvalid_o,
    input  wire                 rready_i,

    // AW channel
    input  wire  [ID_W-1:0]     awid_i,
    input  wire  [ADDR_W-1:0]   awaddr_i,
    input  wire                 awvalid_i,
    output logic                awready_o,

    // W channel
    input  wire  [DATA_W-1:0]   wdata_i,
    input  wire                 wvalid_i,
    output logic                wready_o,

    // B channel
    output wr_resp_t            b_resp_o,
    output logic                bvalid_o,
    input  wire                 bready_i
);

    logic [ADDR_W-1:0]  req_addr;
    logic [INDEX_W-1:0] dec_index;
    logic               dec_in_range;
    logic [INDEX_W-1:0] store_index;
    logic               line_rd;
    logic               line_wr;
    logic               tag_rd;
    logic               tag_wr;
    logic [ID_W-1:0]    resp_id;
    cxl_resp_e          resp;
    logic [DATA_W-1:0]  line_data;
    line_tag_t          line_tag;

    cxl_mem_ctrl cxl_mem_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .arid_i     (arid_i),
        .araddr_i   (araddr_i),
        .arvalid_i  (arvalid_i),
        .arready_o  (arready_o),
        .rvalid_o   (rvalid_o),
        .rready_i   (rready_i),
        .awid_i     (awid_i),
        .awaddr_i   (awaddr_i),
        .awvalid_i  (awvalid_i),
        .awready_o  (awready_o),
        .wvalid_i   (wvalid_i),
        .wready_o   (wready_o),
        .bvalid_o   (bvalid_o),
        .bready_i   (bready_i),
        .req_addr_o (req_addr),
        .index_i    (dec_index),
        .in_range_i (dec_in_range),
        .line_rd_o  (line_rd),
        .line_wr_o  (line_wr),
        .tag_rd_o   (tag_rd),
        .tag_wr_o   (tag_wr),
        .index_o    (store_index),
        .resp_id_o  (resp_id),
        .resp_o     (resp)
    );

    cxl_addr_decode cxl_addr_decode_inst (
        .addr_i     (req_addr),
        .index_o    (dec_index),
        .in_range_o (dec_in_range)
    );

    cxl_line_store cxl_line_store_inst (
        .clk     (clk),
        .rd_i    (line_rd),
        .wr_i    (line_wr),
        .index_i (store_index),
        .wdata_i (wdata_i),
        .rdata_o (line_data)
    );

    // Writer ID is the captured AW ID
    cxl_tag_store cxl_tag_store_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_i    (tag_rd),
        .wr_i    (tag_wr),
        .index_i (store_index),
        .owner_i (resp_id),
        .tag_o   (line_tag)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Response payloads
    ////////////////////////////////////////////////////////////////////////////

    // Error beats carry no stale line contents
    always_comb begin
        r_beat_o.id   = resp_id;
        r_beat_o.resp = resp;
        if (resp == RESP_OKAY) begin
            r_beat_o.tag  = line_tag;
            r_beat_o.data = line_data;
        end else begin
            r_beat_o.tag  = '0;
            r_beat_o.data = '0;
        end
    end

    always_comb begin
        b_resp_o.id   = resp_id;
        b_resp_o.resp = resp;
    end

endmodule

`default_nettype wire

/* bench/cxl_mem_slave_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_mem_slave_asserts
    import cxl_mem_pkg::*;
(
    input wire             clk,
    input wire             rst_n,
    input wire [2:0]       state_i,
    input wire             arvalid_i,
    input wire             arready_i,
    input wire             awready_i,
    input wire             wready_i,
    input wire             rvalid_i,
    input wire             rready_i,
    input wire             bvalid_i,
    input wire             bready_i,
    input wire [ID_W-1:0]  resp_id_i,
    input wire [1:0]       resp_i
);

    logic ar_hs;

    assign ar_hs = arready_i && arvalid_i;

    // Responses hold with their payload until taken
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !rready_i |=> rvalid_i && $stable(resp_id_i) && $stable(resp_i))
        else $error("R response dropped or changed before acceptance");

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i && !bready_i |=> bvalid_i && $stable(resp_id_i) && $stable(resp_i))
        else $error("B response dropped or changed before acceptance");

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(awready_i && arready_i))
        else $error("awready and arready asserted together");

    // Everything quiet and idle through reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !awready_i && !arready_i && !wready_i && !rvalid_i && !bvalid_i
                   && state_i == ST_IDLE)
        else $error("Handshake output high or FSM busy in reset");

    // Read data two cycles after AR, never earlier
    a_r_after_ar: assert property (@(posedge clk) disable iff (!rst_n)
        $past(ar_hs, 2) |-> rvalid_i)
        else $error("rvalid missing two cycles after AR handshake");

    a_r_rise: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !$past(rvalid_i) |-> $past(ar_hs, 2))
        else $error("rvalid rose without an AR handshake two cycles before");

endmodule

bind cxl_mem_ctrl cxl_mem_slave_asserts cxl_mem_slave_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .state_i   (state_q),
    .arvalid_i (arvalid_i),
    .arready_i (arready_o),
    .awready_i (awready_o),
    .wready_i  (wready_o),
    .rvalid_i  (rvalid_o),
    .rready_i  (rready_i),
    .bvalid_i  (bvalid_o),
    .bready_i  (bready_i),
    .resp_id_i (resp_id_o),
    .resp_i    (resp_o)
);

`default_nettype wire

/* bench/cxl_mem_slave_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_mem_slave_tb
    import cxl_mem_pkg::*;
();

    localparam int TXN_COUNT   = 400;
    // Well under a dozen cycles per transaction on average, plus margin
    localparam int CYCLE_LIMIT = TXN_COUNT * 12 + 500;

    localparam int KIND_DATA  = 0;
    localparam int KIND_RESP  = 1;
    localparam int KIND_PROTO = 2;

    logic              clk;
    logic              rst_n;
    logic [ID_W-1:0]   arid;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    rd_beat_t          r_beat;
    logic              rvalid;
    logic              rready;
    logic [ID_W-1:0]   awid;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic              wvalid;
    logic              wready;
    wr_resp_t          b_resp;
    logic              bvalid;
    logic              bready;

    // Reference model, one entry per line
    logic [DATA_W-1:0] model_line    [LINE_COUNT];
    logic              model_written [LINE_COUNT];
    logic [ID_W-1:0]   model_owner   [LINE_COUNT];
    int                model_writes  [LINE_COUNT];
    logic              prefer_write;

    // Transaction being run
    logic [ID_W-1:0]   w_id;
    logic [ADDR_W-1:0] w_addr;
    logic [DATA_W-1:0] w_data;
    int                w_idx;
    logic              w_ok;
    logic [ID_W-1:0]   r_id;
    logic [ADDR_W-1:0] r_addr;
    int                r_idx;
    logic              r_ok;

    integer seed;
    int     cycle_count = 0;
    int     err_data;
    int     err_resp;
    int     err_proto;

    cxl_mem_slave cxl_mem_slave_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .arid_i    (arid),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .r_beat_o  (r_beat),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .awid_i    (awid),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .b_resp_o  (b_resp),
        .bvalid_o  (bvalid),
        .bready_i  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: transactions still running after %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic record_error(input int kind, input string msg);
        $display("FAIL @ %0t: %s", $time, msg);
        case (kind)
            KIND_DATA: err_data++;
            KIND_RESP: err_resp++;
            default:   err_proto++;
        endcase
    endtask

    // Tag as the model expects it, zero for a line never written
    function automatic line_tag_t expected_tag(input int idx);
        line_tag_t t;
        t = '0;
        if (model_written[idx]) begin
            t.written  = 1'b1;
            t.owner_id = model_owner[idx];
            t.version  = VER_W'(model_writes[idx] % 256);
        end
        return t;
    endfunction

    // 60% in range, 20% outside the window, 20% misaligned
    task automatic pick_addr(output logic [ADDR_W-1:0] addr, output int idx, output logic ok);
        int                roll;
        int                pick;
        logic [ADDR_W-1:0] line_addr;
        roll = rand_below(10);
        pick = rand_below(64);
        // Mostly a few lines so reads land on earlier writes
        if (rand_below(4) != 0) begin
            idx = rand_below(16);
        end else begin
            idx = rand_below(LINE_COUNT);
        end
        line_addr = HDM_BASE + ADDR_W'(idx * LINE_BYTES);
        ok = (roll < 6);
        if (roll < 6) begin
            addr = line_addr;
        end else if (roll < 8) begin
            if (pick % 2 == 1) begin
                addr = HDM_BASE - ADDR_W'((pick + 1) * LINE_BYTES);
            end else begin
                addr = HDM_BASE + ADDR_W'((LINE_COUNT + pick) * LINE_BYTES);
            end
        end else begin
            addr = line_addr + ADDR_W'(pick % 63 + 1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Channel sequences
    ////////////////////////////////////////////////////////////////////////////

    // Entered just after the edge before the first expected response cycle
    task automatic accept_resp(input logic is_read, input rd_beat_t exp_r,
                               input logic check_data, input wr_resp_t exp_b);
        int delay;
        int k;
        delay = rand_below(4);
        if (is_read) rready <= (delay == 0);
        else bready <= (delay == 0);
        for (k = 0; k <= delay; k++) begin
            @(negedge clk);
            if (awready || arready || wready) begin
                record_error(KIND_PROTO, "ready raised while a response is pending");
            end
            if (is_read) begin
                if (rvalid !== 1'b1) begin
                    record_error(KIND_PROTO, "rvalid low in a response cycle");
                end
                if (r_beat.id !== exp_r.id || r_beat.resp !== exp_r.resp) begin
                    record_error(KIND_RESP, $sformatf("R id/resp %h/%0d, expected %h/%0d",
                        r_beat.id, r_beat.resp, exp_r.id, exp_r.resp));
                end
                if (r_beat.tag !== exp_r.tag) begin
                    record_error(KIND_DATA, $sformatf("R tag %h, expected %h",
                        r_beat.tag, exp_r.tag));
                end
                if (check_data && r_beat.data !== exp_r.data) begin
                    record_error(KIND_DATA, $sformatf("R data mismatch for id %h", exp_r.id));
                end
            end else begin
                if (bvalid !== 1'b1) begin
                    record_error(KIND_PROTO, "bvalid low in a response cycle");
                end
                if (b_resp !== exp_b) begin
                    record_error(KIND_RESP, $sformatf("B id/resp %h/%0d, expected %h/%0d",
                        b_resp.id, b_resp.resp, exp_b.id, exp_b.resp));
                end
            end
            @(posedge clk);
            if (is_read) rready <= (k + 1 == delay);
            else bready <= (k + 1 == delay);
        end
    endtask

    // Entered just after the AW handshake edge
    task automatic run_write();
        logic     w_done;
        logic     rdy_seen;
        wr_resp_t exp_b;
        rd_beat_t no_beat;
        awvalid <= 1'b0;
        wdata   <= w_data;
        wvalid  <= (rand_below(2) == 0);
        w_done   = 1'b0;
        rdy_seen = 1'b0;
        while (!w_done) begin
            @(negedge clk);
            if (bvalid || awready || arready) begin
                record_error(KIND_PROTO, "unexpected output high in the write data phase");
            end
            // Once up, wready has to stay up until the data is taken
            if (rdy_seen && wready !== 1'b1) begin
                record_error(KIND_PROTO, "wready dropped before the write data arrived");
            end
            rdy_seen = rdy_seen || (wready === 1'b1);
            w_done = wready && wvalid;
            @(posedge clk);
            wvalid <= !w_done;
        end
        if (w_ok) begin
            model_line[w_idx]    = w_data;
            model_written[w_idx] = 1'b1;
            model_owner[w_idx]   = w_id;
            model_writes[w_idx]  = model_writes[w_idx] + 1;
        end
        exp_b.id   = w_id;
        exp_b.resp = w_ok ? RESP_OKAY : RESP_SLVERR;
        no_beat    = '0;
        accept_resp(1'b0, no_beat, 1'b0, exp_b);
    endtask

    // Entered just after the AR handshake edge
    task automatic run_read();
        rd_beat_t exp_r;
        wr_resp_t no_resp;
        logic     check_data;
        arvalid <= 1'b0;
        exp_r.id   = r_id;
        exp_r.resp = r_ok ? RESP_OKAY : RESP_SLVERR;
        exp_r.tag  = r_ok ? expected_tag(r_idx) : '0;
        exp_r.data = r_ok ? model_line[r_idx] : '0;
        // Contents of a line never written are undefined
        check_data = !r_ok || model_written[r_idx];
        no_resp    = '0;
        @(negedge clk);
        if (rvalid !== 1'b0 || awready || arready || wready) begin
            record_error(KIND_PROTO, "rvalid or a ready high one cycle after AR");
        end
        @(posedge clk);
        accept_resp(1'b1, exp_r, check_data, no_resp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int   t;
        int   kind;
        int   w;
        logic pend_w;
        logic pend_r;
        seed    = 76;
        rst_n   = 1'b0;
        arid    = '0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        err_data  = 0;
        err_resp  = 0;
        err_proto = 0;
        prefer_write = 1'b1;
        for (w = 0; w < LINE_COUNT; w++) begin
            model_written[w] = 1'b0;
            model_writes[w]  = 0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (t = 0; t < TXN_COUNT; t++) begin
            // Write only, read only, or both valids together
            kind   = rand_below(5);
            pend_w = (kind < 2) || (kind == 4);
            pend_r = (kind >= 2);
            pick_addr(w_addr, w_idx, w_ok);
            pick_addr(r_addr, r_idx, r_ok);
            w_id = ID_W'($random(seed));
            r_id = ID_W'($random(seed));
            for (w = 0; w < 16; w++) begin
                w_data[w*32 +: 32] = $random(seed);
            end
            @(posedge clk);
            if (pend_w) begin
                awvalid <= 1'b1;
                awid    <= w_id;
                awaddr  <= w_addr;
            end
            if (pend_r) begin
                arvalid <= 1'b1;
                arid    <= r_id;
                araddr  <= r_addr;
            end
            while (pend_w || pend_r) begin
                @(negedge clk);
                if (awready && arready) begin
                    record_error(KIND_PROTO, "awready and arready high together");
                end
                if (wready) begin
                    record_error(KIND_PROTO, "wready high outside the write data phase");
                end
                if (awready && pend_w) begin
                    if (pend_r && !prefer_write) begin
                        record_error(KIND_PROTO, "write granted when read was due");
                    end
                    @(posedge clk);
                    pend_w = 1'b0;
                    prefer_write = 1'b0;
                    run_write();
                end else if (arready && pend_r) begin
                    if (pend_w && prefer_write) begin
                        record_error(KIND_PROTO, "read granted when write was due");
                    end
                    @(posedge clk);
                    pend_r = 1'b0;
                    prefer_write = 1'b1;
                    run_read();
                end else begin
                    if (awready || arready) begin
                        record_error(KIND_PROTO, "ready raised without a pending request");
                    end
                    @(posedge clk);
                end
            end
        end

        repeat (2) @(posedge clk);
        $display("Errors: data %0d, response %0d, protocol %0d", err_data, err_resp, err_proto);
        if (err_data + err_resp + err_proto == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cxl_mem_slave.f */
logic/cxl_mem_pkg.sv
logic/cxl_addr_decode.sv
logic/cxl_line_store.sv
logic/cxl_tag_store.sv
logic/cxl_mem_ctrl.sv
logic/cxl_mem_slave.sv
bench/cxl_mem_slave_asserts.sv
bench/cxl_mem_slave_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := cxl_mem_slave_tb
FILELIST  := cxl_mem_slave.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
